// File: logic/lpbk_config.svh
// ****************************
// Loopback AFU configuration
// Line widths, index width and line FIFO sizing
// ****************************
`ifndef LPBK_CONFIG_SVH
`define LPBK_CONFIG_SVH

// Host line interface
`define LPBK_ADDR_W 16      // Line address, in lines
`define LPBK_DATA_W 64      // One data line
`define LPBK_IDX_W 8        // Line index and line count

// Line FIFO, also the read credit limit
`define LPBK_FIFO_DEPTH 8
`define LPBK_FIFO_PTR_W 3   // Holds 0 .. DEPTH-1
`define LPBK_FIFO_CNT_W 4   // Holds 0 .. DEPTH

`endif

// File: logic/lpbk_pkg.sv
// ****************************
// Loopback AFU types
// Line vectors, host channel structs and control states
// ****************************
`default_nettype none
`include "lpbk_config.svh"

package lpbk_pkg;

  // Plain vectors
  typedef logic [`LPBK_ADDR_W-1:0] line_addr_t;
  typedef logic [`LPBK_DATA_W-1:0] line_data_t;
  typedef logic [`LPBK_IDX_W-1:0] line_idx_t;
  typedef logic [`LPBK_FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [`LPBK_FIFO_CNT_W-1:0] fifo_cnt_t;    // Occupancy or credits

  // Job descriptor, latched on start
  typedef struct packed {
    line_addr_t src;          // First source line
    line_addr_t dst;          // First destination line
    line_idx_t  num_lines;
  } lpbk_cfg_t;

  // ****************************
  // Host channels
  // ****************************
  typedef struct packed {
    logic       valid;
    line_addr_t addr;
    line_idx_t  mdata;        // Line index, echoed in the response
  } c0_tx_t;

  typedef struct packed {
    logic       valid;
    line_data_t data;
    line_idx_t  mdata;
  } c0_rx_t;

  typedef struct packed {
    logic       valid;
    line_addr_t addr;
    line_data_t data;
  } c1_tx_t;

  // One buffered read response
  typedef struct packed {
    line_idx_t  idx;
    line_data_t data;
  } line_entry_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } ctl_state_t;

endpackage

`default_nettype wire

// File: logic/lpbk_ctl.sv
// ****************************
// Loopback control
// Latches the job on start, tracks busy, counts write
// acknowledgements and holds done until the next start
// ****************************
`timescale 1ns/1ns
`default_nettype none

module lpbk_ctl (
  input  wire logic                pClk,
  input  wire logic                rst_n,
  input  wire logic                start,       // One-cycle pulse from host
  input  wire lpbk_pkg::lpbk_cfg_t cfg,
  input  wire logic                c1_rx_ack,   // One strobe per completed write
  output lpbk_pkg::lpbk_cfg_t      job,
  output logic                     run_start,   // Kicks the read engine
  output logic                     busy,
  output logic                     done
);

  lpbk_pkg::ctl_state_t state;
  lpbk_pkg::line_idx_t  ack_cnt;              // Writes acknowledged so far
  logic                 start_ok;
  logic                 last_ack;

  // Start is dropped while a job runs
  assign start_ok = start && (state != lpbk_pkg::RUN);
  assign last_ack = c1_rx_ack &&
                    (lpbk_pkg::line_idx_t'(ack_cnt + 1'b1) == job.num_lines);

  // ****************************
  // Control FSM
  // ****************************
  always_ff @(posedge pClk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= lpbk_pkg::IDLE;
      ack_cnt   <= '0;
      run_start <= 1'b0;
    end
    else
    begin
      run_start <= start_ok;                  // Lines up with the first busy cycle
      case (state)
        lpbk_pkg::IDLE,
        lpbk_pkg::DONE:
        begin
          if (start_ok)
          begin
            state   <= lpbk_pkg::RUN;
            ack_cnt <= '0;
          end
        end
        lpbk_pkg::RUN:
        begin
          // Zero-line job has nothing to wait for
          if (job.num_lines == '0)
            state <= lpbk_pkg::DONE;
          else if (c1_rx_ack)
          begin
            ack_cnt <= ack_cnt + 1'b1;
            if (last_ack)
              state <= lpbk_pkg::DONE;     // done shows one cycle after this ack
          end
        end
        default: state <= lpbk_pkg::IDLE;
      endcase
    end
  end

  // Job descriptor
  always_ff @(posedge pClk)
  begin
    if (start_ok)
      job <= cfg;
  end

  assign busy = (state == lpbk_pkg::RUN);
  assign done = (state == lpbk_pkg::DONE);    // Held until next accepted start

endmodule

`default_nettype wire

// File: logic/lpbk_rd_engine.sv
// ****************************
// Loopback read engine
// Issues one read per source line, throttled by the host
// almost-full level and by line FIFO credits
// ****************************
`timescale 1ns/1ns
`default_nettype none
`include "lpbk_config.svh"

module lpbk_rd_engine (
  input  wire logic                pClk,
  input  wire logic                rst_n,
  input  wire logic                run_start,
  input  wire lpbk_pkg::lpbk_cfg_t job,
  input  wire logic                c0_tx_alm_full,
  input  wire logic                pop,           // Frees one FIFO slot
  output lpbk_pkg::c0_tx_t         c0_tx
);

  lpbk_pkg::line_idx_t next_idx;               // Index of the next request
  lpbk_pkg::fifo_cnt_t credits;                // Free FIFO slots not yet claimed
  logic                running;
  logic                issue;

  // One request per cycle at most
  assign issue = running &&
                 !c0_tx_alm_full &&
                 (credits != '0) &&
                 (next_idx != job.num_lines);

  // ****************************
  // Request sequencing
  // ****************************
  always_ff @(posedge pClk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      running  <= 1'b0;
      next_idx <= '0;
      credits  <= lpbk_pkg::fifo_cnt_t'(`LPBK_FIFO_DEPTH);
    end
    else if (run_start)
    begin
      running  <= 1'b1;
      next_idx <= '0;
      credits  <= lpbk_pkg::fifo_cnt_t'(`LPBK_FIFO_DEPTH);  // Whole FIFO free
    end
    else
    begin
      if (next_idx == job.num_lines)
        running <= 1'b0;                       // All requests sent
      if (issue)
        next_idx <= next_idx + 1'b1;
      case ({issue, pop})
        2'b10:   credits <= credits - 1'b1;    // Slot claimed
        2'b01:   credits <= credits + 1'b1;    // Slot returned by consumer
        default: credits <= credits;           // Both or neither
      endcase
    end
  end

  // Registered request, valid cleared when not issuing
  always_ff @(posedge pClk or negedge rst_n)
  begin
    if (!rst_n)
      c0_tx <= '0;
    else
    begin
      c0_tx.valid <= issue;
      if (issue)
      begin
        c0_tx.addr  <= job.src + lpbk_pkg::line_addr_t'(next_idx);
        c0_tx.mdata <= next_idx;               // Response returns it
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/lpbk_line_fifo.sv
// ****************************
// Loopback line FIFO
// Circular buffer of read responses, stored with the line
// index so they may arrive in any order
// ****************************
`timescale 1ns/1ns
`default_nettype none
`include "lpbk_config.svh"

module lpbk_line_fifo (
  input  wire logic             pClk,
  input  wire logic             rst_n,
  input  wire lpbk_pkg::c0_rx_t c0_rx,
  input  wire logic             pop,
  output lpbk_pkg::line_entry_t head,
  output logic                  not_empty
);

  localparam lpbk_pkg::fifo_ptr_t LAST_SLOT = lpbk_pkg::fifo_ptr_t'(`LPBK_FIFO_DEPTH - 1);

  lpbk_pkg::line_entry_t mem [`LPBK_FIFO_DEPTH];
  lpbk_pkg::fifo_ptr_t   wr_ptr;
  lpbk_pkg::fifo_ptr_t   rd_ptr;
  lpbk_pkg::fifo_cnt_t   count;                // Entries held
  logic                  push;

  // Every valid response is a push, credits keep it from overflowing
  assign push = c0_rx.valid;

  // Storage
  always_ff @(posedge pClk)
  begin
    if (push)
    begin
      mem[wr_ptr].idx  <= c0_rx.mdata;
      mem[wr_ptr].data <= c0_rx.data;
    end
  end

  // ****************************
  // Pointers and occupancy
  // ****************************
  always_ff @(posedge pClk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;   // Wrap
      if (pop)
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // New entry shows at head the cycle after its push
  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

endmodule

`default_nettype wire

// File: logic/lpbk_wr_engine.sv
// ****************************
// Loopback write engine
// Drains the line FIFO and writes each line to the
// destination region at its own index
// ****************************
`timescale 1ns/1ns
`default_nettype none

module lpbk_wr_engine (
  input  wire logic                  pClk,
  input  wire logic                  rst_n,
  input  wire lpbk_pkg::lpbk_cfg_t   job,
  input  wire logic                  not_empty,
  input  wire lpbk_pkg::line_entry_t head,
  input  wire logic                  c1_tx_alm_full,
  output logic                       pop,       // Also returns a read credit
  output lpbk_pkg::c1_tx_t           c1_tx
);

  // Pop only when the write can go out next cycle
  assign pop = not_empty && !c1_tx_alm_full;

  // ****************************
  // Write request register
  // ****************************
  always_ff @(posedge pClk or negedge rst_n)
  begin
    if (!rst_n)
      c1_tx <= '0;
    else
    begin
      c1_tx.valid <= pop;                       // One write per pop
      if (pop)
      begin
        // Index picks the slot, so response order does not matter
        c1_tx.addr <= job.dst + lpbk_pkg::line_addr_t'(head.idx);
        c1_tx.data <= head.data;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/lpbk_afu.sv
// ****************************
// Loopback AFU top level
// Copies a run of lines from a source to a destination
// region over the host read and write channels
// ****************************
`timescale 1ns/1ns
`default_nettype none

module lpbk_afu (
  input  wire logic                pClk,
  input  wire logic                rst_n,

  // Job control
  input  wire logic                start,
  input  wire lpbk_pkg::lpbk_cfg_t cfg,
  output logic                     busy,
  output logic                     done,

  // Host flow control, levels
  input  wire logic                c0_tx_alm_full,
  input  wire logic                c1_tx_alm_full,

  // Host channels
  input  wire lpbk_pkg::c0_rx_t    c0_rx,        // Read responses
  input  wire logic                c1_rx_ack,    // Write acknowledge
  output lpbk_pkg::c0_tx_t         c0_tx,        // Read requests
  output lpbk_pkg::c1_tx_t         c1_tx         // Write requests
);

  lpbk_pkg::lpbk_cfg_t   job;
  lpbk_pkg::line_entry_t head;
  logic                  run_start;
  logic                  pop;
  logic                  not_empty;

  // ****************************
  // Control
  // ****************************
  lpbk_ctl u_ctl (
    .pClk      (pClk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg       (cfg),
    .c1_rx_ack (c1_rx_ack),
    .job       (job),
    .run_start (run_start),
    .busy      (busy),
    .done      (done)
  );

  // Producer
  lpbk_rd_engine u_rd_engine (
    .pClk           (pClk),
    .rst_n          (rst_n),
    .run_start      (run_start),
    .job            (job),
    .c0_tx_alm_full (c0_tx_alm_full),
    .pop            (pop),             // Credit return
    .c0_tx          (c0_tx)
  );

  // Buffer, fed straight from the read response channel
  lpbk_line_fifo u_line_fifo (
    .pClk      (pClk),
    .rst_n     (rst_n),
    .c0_rx     (c0_rx),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty)
  );

  // Consumer
  lpbk_wr_engine u_wr_engine (
    .pClk           (pClk),
    .rst_n          (rst_n),
    .job            (job),
    .not_empty      (not_empty),
    .head           (head),
    .c1_tx_alm_full (c1_tx_alm_full),
    .pop            (pop),
    .c1_tx          (c1_tx)
  );

endmodule

`default_nettype wire

// File: tests/host_mem_model.sv
// ****************************
// Host memory model
// Returns read lines after a random delay, out of order,
// stores written lines and acknowledges them later
// ****************************
`timescale 1ns/1ns
`default_nettype none
`include "lpbk_config.svh"

module host_mem_model (
  input  wire logic             pClk,
  input  wire logic             rst_n,
  input  wire lpbk_pkg::c0_tx_t c0_tx,      // Read requests from the AFU
  input  wire lpbk_pkg::c1_tx_t c1_tx,      // Write requests from the AFU
  output lpbk_pkg::c0_rx_t      c0_rx,      // Read responses
  output logic                  c1_rx_ack   // One strobe per write
);

  // Pending read, data captured when the request arrives
  typedef struct packed {
    logic [31:0]          due;
    lpbk_pkg::line_idx_t  idx;
    lpbk_pkg::line_data_t data;
  } rd_pend_t;

  lpbk_pkg::line_data_t mem [1 << `LPBK_ADDR_W];
  rd_pend_t             rd_q [$];
  logic [31:0]          ack_q [$];          // Due cycle of each pending ack
  logic [31:0]          now;                // Cycle counter

  // Random lines, low word mixed with the address
  initial
  begin
    for (int a = 0; a < (1 << `LPBK_ADDR_W); a++)
      mem[a] = {$urandom(), $urandom() ^ 32'(a)};
  end

  // ****************************
  // Request handling
  // ****************************
  always @(posedge pClk or negedge rst_n)
  begin
    int pick;
    if (!rst_n)
    begin
      c0_rx     <= '0;
      c1_rx_ack <= 1'b0;
      now = '0;
      rd_q.delete();
      ack_q.delete();
    end
    else
    begin
      now = now + 1;
      if (c0_tx.valid)                      // Delay of 1 to 6 cycles
        rd_q.push_back(rd_pend_t'{due: now + $urandom_range(5, 0), idx: c0_tx.mdata,
                                  data: mem[c0_tx.addr]});
      // First ready entry, random delays reorder them
      pick = -1;
      foreach (rd_q[i])
        if (pick < 0 && rd_q[i].due <= now)
          pick = i;
      if (pick >= 0)
      begin
        c0_rx <= lpbk_pkg::c0_rx_t'{valid: 1'b1, data: rd_q[pick].data,
                                    mdata: rd_q[pick].idx};
        rd_q.delete(pick);
      end
      else
        c0_rx.valid <= 1'b0;

      if (c1_tx.valid)
      begin
        mem[c1_tx.addr] = c1_tx.data;
        ack_q.push_back(now + $urandom_range(4, 0));
      end
      c1_rx_ack <= 1'b0;
      if (ack_q.size() != 0 && ack_q[0] <= now)   // At most one ack per cycle
      begin
        c1_rx_ack <= 1'b1;
        void'(ack_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_lpbk_afu.sv
// ****************************
// Loopback AFU testbench
// Random copy jobs under random almost-full levels
// checked against a copy of the source lines
// ****************************
`timescale 1ns/1ns
`default_nettype none
`include "lpbk_config.svh"

module tb_lpbk_afu;

  localparam int TIMEOUT_CYC = 5000;        // Per wait
  localparam int NUM_JOBS    = 6;

  logic                 pClk           = 1'b0;
  logic                 rst_n          = 1'b1;
  logic                 start          = 1'b0;
  lpbk_pkg::lpbk_cfg_t  cfg            = '0;
  logic                 c0_tx_alm_full = 1'b0;
  logic                 c1_tx_alm_full = 1'b0;
  lpbk_pkg::c0_rx_t     c0_rx;
  logic                 c1_rx_ack;
  lpbk_pkg::c0_tx_t     c0_tx;
  lpbk_pkg::c1_tx_t     c1_tx;
  logic                 busy;
  logic                 done;

  // Job window that the main process sets while idle
  int cur_src;
  int cur_dst;
  int cur_num;
  // Traffic seen by the monitor
  int rd_total;
  int rd_in_range;
  int wr_stray;
  int wr_hits [256];                        // Writes per destination line
  int rd_issued;                            // Whole run
  int wr_issued;
  logic af0_prev = 1'b0;
  logic af1_prev = 1'b0;
  int errors;
  int job_errs;
  int jobs_run;
  logic timed_out = 1'b0;
  lpbk_pkg::line_data_t ref_lines [256];    // Source lines copied before each job

  always #50 pClk = ~pClk;

  lpbk_afu uut (
    .pClk(pClk), .rst_n(rst_n), .start(start), .cfg(cfg), .busy(busy), .done(done),
    .c0_tx_alm_full(c0_tx_alm_full), .c1_tx_alm_full(c1_tx_alm_full),
    .c0_rx(c0_rx), .c1_rx_ack(c1_rx_ack), .c0_tx(c0_tx), .c1_tx(c1_tx)
  );

  host_mem_model u_host (
    .pClk(pClk), .rst_n(rst_n), .c0_tx(c0_tx), .c1_tx(c1_tx),
    .c0_rx(c0_rx), .c1_rx_ack(c1_rx_ack)
  );

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("FAIL %s: got %0h, expected %0h", name, got, exp);
    errors++;
    job_errs++;
  endtask

  task automatic note_failure(input string msg);
    $display("%0t ns: %s", $time, msg);
    errors++;
    job_errs++;
  endtask

  // Almost-full levels high about 1 in 4 cycles
  always @(posedge pClk)
  begin
    if (rst_n)
    begin
      c0_tx_alm_full <= ($urandom_range(3, 0) == 0);
      c1_tx_alm_full <= ($urandom_range(3, 0) == 0);
    end
  end

  // ****************************
  // Channel monitor
  // ****************************
  always @(negedge pClk)
  begin
    if (rst_n)
    begin
      assert (!(c0_tx.valid && af0_prev))
      else note_failure("read request issued in the cycle after c0_tx_alm_full was high");
      assert (!(c1_tx.valid && af1_prev))
      else note_failure("write request issued in the cycle after c1_tx_alm_full was high");
      if (c0_tx.valid)
      begin
        rd_issued++;
        rd_total++;
        if (int'(c0_tx.addr) >= cur_src && int'(c0_tx.addr) < cur_src + cur_num)
          rd_in_range++;
      end
      if (c1_tx.valid)
      begin
        wr_issued++;
        if (int'(c1_tx.addr) >= cur_dst && int'(c1_tx.addr) < cur_dst + cur_num)
          wr_hits[int'(c1_tx.addr) - cur_dst]++;
        else
          wr_stray++;
      end
      assert (rd_issued - wr_issued <= `LPBK_FIFO_DEPTH)
      else note_failure($sformatf("%0d reads outstanding, above the FIFO depth",
                                  rd_issued - wr_issued));
    end
    af0_prev = c0_tx_alm_full;              // Applies to the next cycle
    af1_prev = c1_tx_alm_full;
  end

  // One copy job with a stray start in the middle
  task automatic run_job(input int n, input int num);
    int src;
    int dst;
    int acks;
    int cyc;
    lpbk_pkg::line_data_t got;
    src = $urandom_range(16'h7E00, 0);      // Source in the low half
    dst = 16'h8000 + $urandom_range(16'h7E00, 0);
    job_errs = 0;
    jobs_run++;
    for (int i = 0; i < num; i++)
      ref_lines[i] = u_host.mem[src + i];
    @(posedge pClk);
    cur_src = src;
    cur_dst = dst;
    cur_num = num;
    rd_total = 0;
    rd_in_range = 0;
    wr_stray = 0;
    foreach (wr_hits[i])
      wr_hits[i] = 0;
    start <= 1'b1;
    cfg   <= lpbk_pkg::lpbk_cfg_t'{src: lpbk_pkg::line_addr_t'(src),
                                   dst: lpbk_pkg::line_addr_t'(dst),
                                   num_lines: lpbk_pkg::line_idx_t'(num)};
    @(negedge pClk);
    assert (!busy) else flag_mismatch("busy", 64'(busy), 64'd0);
    assert (n == 0 || done) else flag_mismatch("done", 64'(done), 64'd1);  // Held from last job
    @(posedge pClk);
    start <= 1'b0;
    @(negedge pClk);
    assert (busy) else flag_mismatch("busy", 64'(busy), 64'd1);
    assert (!done) else flag_mismatch("done", 64'(done), 64'd0);

    // Start while busy must be dropped
    @(posedge pClk);
    start <= 1'b1;
    cfg   <= lpbk_pkg::lpbk_cfg_t'({$urandom(), 8'(dst)});
    @(posedge pClk);
    start <= 1'b0;
    @(negedge pClk);
    assert (busy) else flag_mismatch("busy", 64'(busy), 64'd1);

    // Count acks until the last one
    acks = 0;
    cyc  = 0;
    while (acks < num && cyc < TIMEOUT_CYC)
    begin
      @(negedge pClk);
      cyc++;
      if (c1_rx_ack)
      begin
        acks++;
        if (acks == num)
        begin
          assert (!done) else flag_mismatch("done", 64'(done), 64'd0);
        end
      end
    end
    if (acks < num)
    begin
      note_failure($sformatf("timed out with %0d of %0d writes acknowledged", acks, num));
      timed_out = 1'b1;
    end
    else
    begin
      @(negedge pClk);
      assert (done) else flag_mismatch("done", 64'(done), 64'd1);
      assert (!busy) else flag_mismatch("busy", 64'(busy), 64'd0);
      for (int i = 0; i < num; i++)
      begin
        got = u_host.mem[lpbk_pkg::line_addr_t'(dst + i)];
        assert (got == ref_lines[i])
        else flag_mismatch($sformatf("mem[%0h]", dst + i), got, ref_lines[i]);
        assert (wr_hits[i] == 1)
        else note_failure($sformatf("line %0h written %0d times", dst + i, wr_hits[i]));
      end
      assert (wr_stray == 0)
      else note_failure($sformatf("%0d writes outside the destination range", wr_stray));
      assert (rd_total == num && rd_in_range == num)
      else note_failure($sformatf("%0d reads, %0d in the source range, for %0d lines",
                                  rd_total, rd_in_range, num));
    end
    $display("job %0d  src %04h  dst %04h  lines %0d  errors %0d",
             n, src, dst, num, job_errs);
  endtask

  // ****************************
  // Main sequence
  // ****************************
  initial
  begin
    int num;
    void'($urandom(32));
    rst_n <= 1'b0;
    repeat (5) @(posedge pClk);
    rst_n <= 1'b1;
    @(negedge pClk);
    assert (!busy) else flag_mismatch("busy", 64'(busy), 64'd0);
    assert (!done) else flag_mismatch("done", 64'(done), 64'd0);
    for (int j = 0; j < NUM_JOBS && !timed_out; j++)
    begin
      case (j)
        0:       num = 1;
        1:       num = 255;                 // Longest job
        default: num = $urandom_range(254, 2);
      endcase
      run_job(j, num);
    end
    $display("%0d jobs run, %0d errors", jobs_run, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/lpbk_pkg.sv
logic/lpbk_ctl.sv
logic/lpbk_rd_engine.sv
logic/lpbk_line_fifo.sv
logic/lpbk_wr_engine.sv
logic/lpbk_afu.sv
tests/host_mem_model.sv
tests/tb_lpbk_afu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lpbk_afu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
